// ==== hw/serial_link_defs.svh ====
`ifndef SERIAL_LINK_DEFS_SVH
`define SERIAL_LINK_DEFS_SVH

// Link geometry
`define SL_NUM_LANES 4
`define SL_FLIT_W 12

// Receive FIFO depth, also the credits the transmitter starts with
`define SL_NUM_CREDITS 4

// Forwarded clock divider
`define SL_CLK_DIV_W 8
`define SL_CLK_DIV_RESET 8'd8

// Configuration register map
`define SL_ADDR_CTRL 2'd0
`define SL_ADDR_ISOLATED 2'd1
`define SL_ADDR_CLK_DIV 2'd2

// Clock enabled, out of reset, both directions isolated
`define SL_CTRL_RESET 4'b1111

`endif

// ==== hw/serial_link_pkg.sv ====
`include "serial_link_defs.svh"

package serial_link_pkg;

  // One NoC flit as seen at the link ports
  typedef logic [`SL_FLIT_W-1:0] flit_t;

  // Header bit on top of the flit
  typedef logic [`SL_FLIT_W:0] payload_t;

  // Data flag, 2-bit credit return, payload (MSB first)
  typedef logic [$bits(payload_t)+2:0] frame_t;

  // Half a frame, two lane halves per beat
  typedef logic [2*`SL_NUM_LANES-1:0] beat_t;

  // What the lanes carry on one forwarded clock edge
  typedef logic [`SL_NUM_LANES-1:0] lane_t;

  // Wide enough for 0 to SL_NUM_CREDITS
  typedef logic [$clog2(`SL_NUM_CREDITS):0] credit_t;

endpackage

// ==== hw/serial_link_cfg_pkg.sv ====
`include "serial_link_defs.svh"

package serial_link_cfg_pkg;

  // Register bus
  typedef logic [1:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  // Half period of the forwarded clock in clk_i cycles
  typedef logic [`SL_CLK_DIV_W-1:0] clk_div_t;

  // Control register, LSB first: clk_ena, reset_n, isolate_in, isolate_out
  typedef logic [3:0] ctrl_t;

endpackage

// ==== hw/serial_link_cfg_regs.sv ====
`include "serial_link_defs.svh"

module serial_link_cfg_regs
  import serial_link_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cfg_we_i,
  input  cfg_addr_t  cfg_addr_i,
  input  cfg_data_t  cfg_wdata_i,
  output cfg_data_t  cfg_rdata_o,
  input  logic [1:0] isolated_i,
  output clk_div_t   clk_div_o,
  output logic       clk_ena_o,
  output logic       reset_no,
  output logic [1:0] isolate_o
);

  ctrl_t    ctrl_q;
  clk_div_t clk_div_q;

  ////////////////////
  // Write side
  ////////////////////

  // The isolation status address has no storage behind it, writes to it
  // fall through to the default branch
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q    <= `SL_CTRL_RESET;
      clk_div_q <= `SL_CLK_DIV_RESET;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        `SL_ADDR_CTRL: begin
          ctrl_q <= cfg_wdata_i[$bits(ctrl_t)-1:0];
        end
        `SL_ADDR_CLK_DIV: begin
          clk_div_q <= cfg_wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      `SL_ADDR_CTRL: begin
        cfg_rdata_o = cfg_data_t'(ctrl_q);
      end
      `SL_ADDR_ISOLATED: begin
        // Bit 0 is the inbound side, bit 1 the outbound side
        cfg_rdata_o = cfg_data_t'(isolated_i);
      end
      `SL_ADDR_CLK_DIV: begin
        cfg_rdata_o = cfg_data_t'(clk_div_q);
      end
      default: begin
        cfg_rdata_o = '0;
      end
    endcase
  end

  ////////////////////
  // Control outputs
  ////////////////////

  assign clk_ena_o = ctrl_q[0];
  assign reset_no  = ctrl_q[1];
  assign isolate_o = ctrl_q[3:2];   // {isolate_out, isolate_in}
  assign clk_div_o = clk_div_q;

endmodule

// ==== hw/serial_link_data_link.sv ====
`include "serial_link_defs.svh"

module serial_link_data_link
  import serial_link_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  flit_valid_i,
  input  flit_t flit_i,
  output logic  flit_ready_o,
  output logic  flit_valid_o,
  output flit_t flit_o,
  input  logic  flit_ready_i,
  output beat_t tx_beat_o,
  output logic  tx_beat_valid_o,
  input  logic  tx_beat_ready_i,
  input  beat_t rx_beat_i,
  input  logic  rx_beat_valid_i
);

  localparam int unsigned data_flag_bit = $bits(frame_t) - 1;
  localparam int unsigned ptr_w = $clog2(`SL_NUM_CREDITS);

  typedef enum logic [1:0] {
    st_idle,
    st_low_beat,
    st_high_beat
  } tx_state_e;

  // Transmit side
  tx_state_e  tx_state_q;
  frame_t     frame_q;
  flit_t      hold_flit_q;
  logic       hold_full_q;
  credit_t    credits_q;
  credit_t    owed_q;
  credit_t    owed_next;
  logic [1:0] ret_cnt;
  payload_t   launch_payload;
  logic       flit_accept;
  logic       tx_free;
  logic       launch_data;
  logic       launch_credit;
  logic       launch;

  // Receive side
  beat_t            rx_low_q;
  logic             rx_half_q;
  frame_t           rx_frame;
  logic             rx_frame_done;
  logic             rx_push;
  logic [1:0]       rx_ret;
  flit_t            fifo_mem_q [`SL_NUM_CREDITS];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  credit_t          fifo_cnt_q;
  logic             fifo_pop;

  ////////////////////
  // Transmit framing
  ////////////////////

  // One flit can wait for a credit, the next one is refused
  assign flit_ready_o = ~hold_full_q;
  assign flit_accept  = flit_valid_i & flit_ready_o;

  // Frame register is free when idle or when its last beat leaves this cycle
  assign tx_free = (tx_state_q == st_idle) |
                   ((tx_state_q == st_high_beat) & tx_beat_ready_i);

  // A pop this cycle already counts as owed, so its credit can ride the next frame
  assign fifo_pop  = flit_valid_o & flit_ready_i;
  assign owed_next = owed_q + credit_t'(fifo_pop);
  assign ret_cnt   = (owed_next > credit_t'(3)) ? 2'd3 : owed_next[1:0];

  // Data frames need a credit, credit-only frames go out whenever something is owed
  assign launch_data   = tx_free & (hold_full_q | flit_accept) & (credits_q != '0);
  assign launch_credit = tx_free & ~launch_data & (owed_next != '0);
  assign launch        = launch_data | launch_credit;

  // Header bit 0 marks the request channel
  always_comb begin
    launch_payload = '0;
    if (launch_data) begin
      launch_payload = {1'b0, (hold_full_q ? hold_flit_q : flit_i)};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hold_full_q <= 1'b0;
      credits_q   <= credit_t'(`SL_NUM_CREDITS);
      owed_q      <= '0;
    end else begin
      if (launch_data) begin
        hold_full_q <= 1'b0;
      end else if (flit_accept) begin
        hold_full_q <= 1'b1;
      end
      credits_q <= credits_q - credit_t'(launch_data) + credit_t'(rx_ret);
      owed_q    <= owed_next - (launch ? credit_t'(ret_cnt) : credit_t'(0));
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_accept) begin
      hold_flit_q <= flit_i;
    end
    if (launch) begin
      frame_q <= {launch_data, ret_cnt, launch_payload};
    end
  end

  ////////////////////
  // Beat split
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_state_q <= st_idle;
    end else if (launch) begin
      tx_state_q <= st_low_beat;
    end else begin
      case (tx_state_q)
        st_low_beat: begin
          if (tx_beat_ready_i) begin
            tx_state_q <= st_high_beat;
          end
        end
        st_high_beat: begin
          if (tx_beat_ready_i) begin
            tx_state_q <= st_idle;
          end
        end
        default: begin
          tx_state_q <= st_idle;
        end
      endcase
    end
  end

  // Low beat first
  assign tx_beat_valid_o = (tx_state_q != st_idle);
  assign tx_beat_o = (tx_state_q == st_high_beat) ? frame_q[data_flag_bit -: $bits(beat_t)]
                                                  : frame_q[$bits(beat_t)-1:0];

  ////////////////////
  // Receive side
  ////////////////////

  assign rx_frame      = {rx_beat_i, rx_low_q};
  assign rx_frame_done = rx_beat_valid_i & rx_half_q;
  assign rx_push       = rx_frame_done & rx_frame[data_flag_bit];
  assign rx_ret        = rx_frame_done ? rx_frame[data_flag_bit-1 -: 2] : 2'd0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_half_q <= 1'b0;
    end else if (rx_beat_valid_i) begin
      rx_half_q <= ~rx_half_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_beat_valid_i && !rx_half_q) begin
      rx_low_q <= rx_beat_i;
    end
  end

  // Receive FIFO, never overflows as long as the far side respects credits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (rx_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + credit_t'(rx_push) - credit_t'(fifo_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_push) begin
      fifo_mem_q[wr_ptr_q] <= rx_frame[$bits(flit_t)-1:0];
    end
  end

  assign flit_valid_o = (fifo_cnt_q != '0);
  assign flit_o       = fifo_mem_q[rd_ptr_q];

endmodule

// ==== hw/serial_link_physical.sv ====
`include "serial_link_defs.svh"

module serial_link_physical
  import serial_link_pkg::*, serial_link_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  clk_div_t clk_div_i,
  input  beat_t    tx_beat_i,
  input  logic     tx_beat_valid_i,
  output logic     tx_beat_ready_o,
  output logic     ddr_rcv_clk_o,
  output lane_t    ddr_o,
  input  logic     ddr_rcv_clk_i,
  input  lane_t    ddr_i,
  output beat_t    rx_beat_o,
  output logic     rx_beat_valid_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_low_half,
    st_high_half
  } tx_state_e;

  tx_state_e tx_state_q;
  clk_div_t  tx_cnt_q;
  clk_div_t  half_div;
  logic      tx_cnt_last;
  logic      tx_mid;
  logic      tx_accept;
  beat_t     tx_beat_q;
  lane_t     ddr_q;
  logic      rcv_clk_q;

  logic [1:0] rx_clk_sync_q;
  lane_t      rx_data_sync1_q;
  lane_t      rx_data_sync2_q;
  logic       rx_clk_prev_q;
  logic       rx_rise;
  logic       rx_fall;
  lane_t      rx_low_q;
  beat_t      rx_beat_q;
  logic       rx_valid_q;

  ////////////////////
  // Transmitter
  ////////////////////

  // Each half lasts clk_div cycles, the clock edge sits in its middle
  assign half_div    = clk_div_i >> 1;
  assign tx_cnt_last = (tx_cnt_q >= clk_div_i - clk_div_t'(1));
  assign tx_mid      = (tx_cnt_q == half_div - clk_div_t'(1));

  // Next beat can be taken on the last cycle of the high half, no gap on the wire
  assign tx_beat_ready_o = (tx_state_q == st_idle) ||
                           ((tx_state_q == st_high_half) && tx_cnt_last);
  assign tx_accept = tx_beat_valid_i & tx_beat_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_state_q <= st_idle;
      tx_cnt_q   <= '0;
      ddr_q      <= '0;
      rcv_clk_q  <= 1'b0;
    end else if (tx_accept) begin
      tx_state_q <= st_low_half;
      tx_cnt_q   <= '0;
      ddr_q      <= tx_beat_i[`SL_NUM_LANES-1:0];
    end else begin
      case (tx_state_q)
        st_low_half: begin
          if (tx_mid) begin
            rcv_clk_q <= 1'b1;
          end
          if (tx_cnt_last) begin
            tx_state_q <= st_high_half;
            tx_cnt_q   <= '0;
            ddr_q      <= tx_beat_q[2*`SL_NUM_LANES-1:`SL_NUM_LANES];
          end else begin
            tx_cnt_q <= tx_cnt_q + clk_div_t'(1);
          end
        end
        st_high_half: begin
          if (tx_mid) begin
            rcv_clk_q <= 1'b0;
          end
          if (tx_cnt_last) begin
            tx_state_q <= st_idle;
            tx_cnt_q   <= '0;
          end else begin
            tx_cnt_q <= tx_cnt_q + clk_div_t'(1);
          end
        end
        default: begin
          // Forwarded clock parks low between beats
          rcv_clk_q <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_accept) begin
      tx_beat_q <= tx_beat_i;
    end
  end

  assign ddr_o         = ddr_q;
  assign ddr_rcv_clk_o = rcv_clk_q;

  ////////////////////
  // Receiver
  ////////////////////

  // Edges are found on the synchronized clock, not in its own domain
  assign rx_rise = rx_clk_sync_q[1] & ~rx_clk_prev_q;
  assign rx_fall = ~rx_clk_sync_q[1] & rx_clk_prev_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_clk_sync_q <= '0;
      rx_clk_prev_q <= 1'b0;
      rx_valid_q    <= 1'b0;
    end else begin
      rx_clk_sync_q <= {rx_clk_sync_q[0], ddr_rcv_clk_i};
      rx_clk_prev_q <= rx_clk_sync_q[1];
      rx_valid_q    <= rx_fall;
    end
  end

  // Lanes take the same two-flop path, so they line up with the clock
  always_ff @(posedge clk_i) begin
    rx_data_sync1_q <= ddr_i;
    rx_data_sync2_q <= rx_data_sync1_q;
    if (rx_rise) begin
      rx_low_q <= rx_data_sync2_q;
    end
    if (rx_fall) begin
      rx_beat_q <= {rx_data_sync2_q, rx_low_q};
    end
  end

  assign rx_beat_o       = rx_beat_q;
  assign rx_beat_valid_o = rx_valid_q;

endmodule

// ==== hw/serial_link.sv ====
module serial_link
  import serial_link_pkg::*, serial_link_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       flit_valid_i,
  input  flit_t      flit_i,
  output logic       flit_ready_o,
  output logic       flit_valid_o,
  output flit_t      flit_o,
  input  logic       flit_ready_i,
  input  logic       cfg_we_i,
  input  cfg_addr_t  cfg_addr_i,
  input  cfg_data_t  cfg_wdata_i,
  output cfg_data_t  cfg_rdata_o,
  input  logic       ddr_rcv_clk_i,
  output logic       ddr_rcv_clk_o,
  input  lane_t      ddr_i,
  output lane_t      ddr_o,
  input  logic [1:0] isolated_i,
  output logic [1:0] isolate_o,
  output logic       clk_ena_o,
  output logic       reset_no
);

  clk_div_t clk_div;
  beat_t    tx_beat;
  logic     tx_beat_valid;
  logic     tx_beat_ready;
  beat_t    rx_beat;
  logic     rx_beat_valid;

  ////////////////////
  // Configuration
  ////////////////////

  serial_link_cfg_regs u_cfg_regs (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .isolated_i  ( isolated_i  ),
    .clk_div_o   ( clk_div     ),
    .clk_ena_o   ( clk_ena_o   ),
    .reset_no    ( reset_no    ),
    .isolate_o   ( isolate_o   )
  );

  ////////////////////
  // Data link layer
  ////////////////////

  serial_link_data_link u_data_link (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .flit_valid_i    ( flit_valid_i  ),
    .flit_i          ( flit_i        ),
    .flit_ready_o    ( flit_ready_o  ),
    .flit_valid_o    ( flit_valid_o  ),
    .flit_o          ( flit_o        ),
    .flit_ready_i    ( flit_ready_i  ),
    .tx_beat_o       ( tx_beat       ),
    .tx_beat_valid_o ( tx_beat_valid ),
    .tx_beat_ready_i ( tx_beat_ready ),
    .rx_beat_i       ( rx_beat       ),
    .rx_beat_valid_i ( rx_beat_valid )
  );

  ////////////////////
  // Physical layer
  ////////////////////

  serial_link_physical u_physical (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .clk_div_i       ( clk_div       ),
    .tx_beat_i       ( tx_beat       ),
    .tx_beat_valid_i ( tx_beat_valid ),
    .tx_beat_ready_o ( tx_beat_ready ),
    .ddr_rcv_clk_o   ( ddr_rcv_clk_o ),
    .ddr_o           ( ddr_o         ),
    .ddr_rcv_clk_i   ( ddr_rcv_clk_i ),
    .ddr_i           ( ddr_i         ),
    .rx_beat_o       ( rx_beat       ),
    .rx_beat_valid_o ( rx_beat_valid )
  );

endmodule

// ==== testbench/serial_link_assertions.sv ====
`include "serial_link_defs.svh"

module serial_link_assertions
  import serial_link_pkg::*, serial_link_cfg_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     beat_valid,
  input logic     beat_ready,
  input beat_t    beat,
  input credit_t  credits,
  input clk_div_t clk_div,
  input logic     beat_busy
);
  timeunit 1ns;
  timeprecision 1ps;

  // A beat offered and not taken stays put with the same value
  valid_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat))
    else $error("beat valid dropped or beat changed before ready");

  credits_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credits <= credit_t'(`SL_NUM_CREDITS))
    else $error("credit counter above the receive FIFO depth");

  // The receiver needs a few clk_i cycles between forwarded clock edges
  clk_div_min_a: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_busy |-> clk_div >= clk_div_t'(4))
    else $error("divider below 4 while a beat is on the wire");

endmodule

bind serial_link_data_link serial_link_assertions u_data_link_assertions (
  .clk_i      ( clk_i                     ),
  .reset_i    ( reset_i                   ),
  .beat_valid ( tx_beat_valid_o           ),
  .beat_ready ( tx_beat_ready_i           ),
  .beat       ( tx_beat_o                 ),
  .credits    ( credits_q                 ),
  .clk_div    ( `SL_CLK_DIV_RESET         ),
  .beat_busy  ( 1'b0                      )
);

bind serial_link_physical serial_link_assertions u_physical_assertions (
  .clk_i      ( clk_i                     ),
  .reset_i    ( reset_i                   ),
  .beat_valid ( tx_beat_valid_i           ),
  .beat_ready ( tx_beat_ready_o           ),
  .beat       ( tx_beat_i                 ),
  .credits    ( '0                        ),
  .clk_div    ( clk_div_i                 ),
  .beat_busy  ( tx_state_q != st_idle     )
);

// ==== testbench/tb_serial_link.sv ====
`include "serial_link_defs.svh"

module tb_serial_link
  import serial_link_pkg::*, serial_link_cfg_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [2:0] {
    op_write, op_read, op_outputs, op_isolated, op_sink, op_send, op_fill, op_drain
  } op_e;

  // arg is the register address or the flit count
  typedef struct packed {
    op_e op;
    int  arg;
    int  value;
    int  expected;
  } entry_t;

  localparam int NUM_ENTRIES = 26;

  entry_t stim_table [NUM_ENTRIES] = '{
    '{op_outputs,  0, 0, `SL_CTRL_RESET},
    '{op_read,     `SL_ADDR_CTRL, 0, `SL_CTRL_RESET},
    '{op_read,     `SL_ADDR_CLK_DIV, 0, 8},
    '{op_write,    `SL_ADDR_CTRL, 4'b0110, 0},
    '{op_outputs,  0, 0, 4'b0110},
    '{op_read,     `SL_ADDR_CTRL, 0, 4'b0110},
    '{op_write,    `SL_ADDR_CTRL, 4'b1001, 0},
    '{op_outputs,  0, 0, 4'b1001},
    '{op_isolated, 0, 2'b10, 0},
    '{op_read,     `SL_ADDR_ISOLATED, 0, 2'b10},
    '{op_write,    `SL_ADDR_ISOLATED, 2'b01, 0},
    '{op_read,     `SL_ADDR_ISOLATED, 0, 2'b10},
    '{op_isolated, 0, 2'b01, 0},
    '{op_read,     `SL_ADDR_ISOLATED, 0, 2'b01},
    '{op_write,    `SL_ADDR_CTRL, `SL_CTRL_RESET, 0},
    '{op_sink,     0, 1, 0},
    '{op_send,     20, 0, 0},
    '{op_sink,     0, 0, 0},
    '{op_fill,     `SL_NUM_CREDITS + 1, 0, `SL_NUM_CREDITS + 1},
    '{op_sink,     0, 1, 0},
    '{op_drain,    0, 0, 0},
    '{op_write,    `SL_ADDR_CLK_DIV, 4, 0},
    '{op_send,     5, 0, 0},
    '{op_write,    `SL_ADDR_CLK_DIV, 20, 0},
    '{op_read,     `SL_ADDR_CLK_DIV, 0, 20},
    '{op_send,     10, 0, 0}
  };

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       flit_valid_i;
  flit_t      flit_i;
  logic       flit_ready_o;
  logic       flit_valid_o;
  flit_t      flit_o;
  logic       flit_ready_i;
  logic       cfg_we_i;
  cfg_addr_t  cfg_addr_i;
  cfg_data_t  cfg_wdata_i;
  cfg_data_t  cfg_rdata_o;
  logic       ddr_rcv_clk;
  lane_t      ddr;
  logic [1:0] isolated_i;
  logic [1:0] isolate_o;
  logic       clk_ena_o;
  logic       reset_no;

  int    seed = 13894;
  int    cur_div = `SL_CLK_DIV_RESET;
  flit_t exp_q [$];

  always #5 clk_i = ~clk_i;

  // Forwarded clock and lanes loop straight back
  serial_link u_serial_link (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .flit_valid_i  ( flit_valid_i ),
    .flit_i        ( flit_i       ),
    .flit_ready_o  ( flit_ready_o ),
    .flit_valid_o  ( flit_valid_o ),
    .flit_o        ( flit_o       ),
    .flit_ready_i  ( flit_ready_i ),
    .cfg_we_i      ( cfg_we_i     ),
    .cfg_addr_i    ( cfg_addr_i   ),
    .cfg_wdata_i   ( cfg_wdata_i  ),
    .cfg_rdata_o   ( cfg_rdata_o  ),
    .ddr_rcv_clk_i ( ddr_rcv_clk  ),
    .ddr_rcv_clk_o ( ddr_rcv_clk  ),
    .ddr_i         ( ddr          ),
    .ddr_o         ( ddr          ),
    .isolated_i    ( isolated_i   ),
    .isolate_o     ( isolate_o    ),
    .clk_ena_o     ( clk_ena_o    ),
    .reset_no      ( reset_no     )
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////
  // Scoreboard
  ////////////////////

  // Sampled at the falling edge, a transfer then happens at the next rising edge
  always @(negedge clk_i) begin
    if (!reset_i && flit_valid_o && flit_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A flit came out of the link although none was outstanding");
        $display("Result: FAILED");
        $fatal(1, "Unexpected flit");
      end else begin
        check_value("flit_o", flit_o, exp_q.pop_front());
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // One beat is 2*div cycles, so a trailing credit frame is gone after 4*div
  task automatic drain_link();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    repeat (4 * cur_div + 16) next_cycle();
  endtask

  task automatic send_flits(input int n, input bit until_stall, output int accepted);
    int  stall;
    logic taken;
    stall = 0;
    accepted = 0;
    flit_valid_i = 1'b1;
    flit_i = flit_t'($random(seed));
    while (until_stall ? (stall < 200) : (accepted < n)) begin
      @(negedge clk_i);
      taken = flit_ready_o;
      next_cycle();
      if (taken) begin
        exp_q.push_back(flit_i);
        accepted++;
        stall = 0;
        flit_i = flit_t'($random(seed));
      end else begin
        stall++;
      end
    end
    flit_valid_i = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    int cnt;
    case (e.op)
      op_write: begin
        cfg_we_i = 1'b1;
        cfg_addr_i = cfg_addr_t'(e.arg);
        cfg_wdata_i = cfg_data_t'(e.value);
        next_cycle();
        cfg_we_i = 1'b0;
        if (e.arg == `SL_ADDR_CLK_DIV) begin
          cur_div = e.value;
        end
      end
      op_read: begin
        cfg_addr_i = cfg_addr_t'(e.arg);
        @(negedge clk_i);
        check_value("cfg_rdata_o", cfg_rdata_o, e.expected);
        next_cycle();
      end
      op_outputs: begin
        @(negedge clk_i);
        check_value("clk_ena_o", clk_ena_o, e.expected[0]);
        check_value("reset_no", reset_no, e.expected[1]);
        check_value("isolate_o", isolate_o, e.expected[3:2]);
        next_cycle();
      end
      op_isolated: isolated_i = e.value[1:0];
      op_sink: flit_ready_i = e.value[0];
      op_send: begin
        send_flits(e.arg, 1'b0, cnt);
        drain_link();
      end
      op_fill: begin
        send_flits(0, 1'b1, cnt);
        check_value("accepted flit count", cnt, e.expected);
      end
      default: drain_link();
    endcase
  endtask

  function automatic longint watchdog_limit_ns();
    longint flits;
    longint max_div;
    flits = 0;
    max_div = `SL_CLK_DIV_RESET;
    foreach (stim_table[k]) begin
      if (stim_table[k].op == op_send || stim_table[k].op == op_fill) begin
        flits += stim_table[k].arg;
      end
      if (stim_table[k].op == op_write && stim_table[k].arg == `SL_ADDR_CLK_DIV &&
          stim_table[k].value > max_div) begin
        max_div = stim_table[k].value;
      end
    end
    return flits * 64 * max_div * 10 + 50000;
  endfunction

  initial begin : watchdog
    longint limit_ns;
    limit_ns = watchdog_limit_ns();
    #(limit_ns);
    $display("The test timed out after %0d ns before all entries were applied", limit_ns);
    $display("Result: FAILED");
    $fatal(1, "Timeout");
  end

  initial begin : main
    reset_i = 1'b1;
    flit_valid_i = 1'b0;
    flit_i = '0;
    flit_ready_i = 1'b1;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    isolated_i = 2'b00;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("flit_valid_o", flit_valid_o, 1'b0);
    check_value("flit_ready_o", flit_ready_o, 1'b1);
    check_value("ddr_o", ddr, '0);
    check_value("ddr_rcv_clk_o", ddr_rcv_clk, 1'b0);
    next_cycle();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_entry(stim_table[i]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hw
hw/serial_link_pkg.sv
hw/serial_link_cfg_pkg.sv
hw/serial_link_cfg_regs.sv
hw/serial_link_data_link.sv
hw/serial_link_physical.sv
hw/serial_link.sv
testbench/serial_link_assertions.sv
testbench/tb_serial_link.sv
